//--- hdl/rv_pkg.sv
// rv32i core shared types
package rv_pkg;

	// data or address word
	typedef logic [31:0] word_t;

	// architectural register number
	typedef logic [4:0] reg_idx_t;

	// alu operations
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_srl,
		alu_pass_b
	} alu_op_e;

	// what execute and memory do with an instruction
	typedef enum logic [2:0] {
		kind_alu,
		kind_load,
		kind_store,
		kind_branch,
		kind_jal
	} kind_e;

	// ******************************
	// major opcodes, inst[6:0]
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_opimm  = 7'b0010011;
	localparam logic [6:0] op_op     = 7'b0110011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

endpackage

//--- hdl/reg_file.sv
// integer register file
`timescale 1ns/1ps

module reg_file (
	input  logic             clk,
	input  rv_pkg::reg_idx_t rs1,
	input  rv_pkg::reg_idx_t rs2,
	output rv_pkg::word_t    rs1_data,
	output rv_pkg::word_t    rs2_data,
	input  logic             wen,
	input  rv_pkg::reg_idx_t rd,
	input  rv_pkg::word_t    wdata
);
	import rv_pkg::*;

	// x0 slot rewritten with zero every cycle
	word_t regs [32];

	// asynchronous read ports
	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

	// single write port from writeback
	always_ff @(posedge clk) begin
		regs[0] <= '0;
		// x0 writes dropped here
		if (wen && (rd != '0)) begin
			regs[rd] <= wdata;
		end
	end

	// a write aimed at x0 must not show up on a later read
	a_x0_rs1: assert property (@(posedge clk)
		(rs1 == '0) |-> (rs1_data == '0));
	a_x0_rs2: assert property (@(posedge clk)
		(rs2 == '0) |-> (rs2_data == '0));

endmodule

//--- hdl/scoreboard.sv
// register busy scoreboard
`timescale 1ns/1ps

module scoreboard (
	input  logic             clk,
	input  logic             rst,
	input  logic             issue_wen,
	input  rv_pkg::reg_idx_t issue_rd,
	input  logic             wb_wen,
	input  rv_pkg::reg_idx_t wb_rd,
	output logic [31:0]      busy
);
	import rv_pkg::*;

	// one pending-write bit per register
	logic [31:0] busy_q;

	assign busy = busy_q;

	// ******************************
	// update
	// clear first, then set
	// so a same-cycle issue to the register wins
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= '0;
		end else begin
			if (wb_wen) begin
				busy_q[wb_rd] <= 1'b0;
			end
			// decode never issues x0
			if (issue_wen) begin
				busy_q[issue_rd] <= 1'b1;
			end
		end
	end

	// ******************************
	// checks
	// x0 is never tracked
	a_x0_idle: assert property (@(posedge clk) disable iff (rst)
		!busy_q[0]);

	// decode holds on a busy destination, so no double issue
	a_no_reissue: assert property (@(posedge clk) disable iff (rst)
		(issue_wen && (issue_rd != '0)) |-> !busy_q[issue_rd]);

endmodule

//--- hdl/fetch_unit.sv
// instruction fetch stage
`timescale 1ns/1ps

module fetch_unit #(
	parameter int imem_depth = 256
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          prog_we,
	input  rv_pkg::word_t prog_addr,
	input  rv_pkg::word_t prog_data,
	input  logic          flush,
	input  rv_pkg::word_t redirect_pc,
	output logic          if_id_valid,
	input  logic          if_id_ready,
	output rv_pkg::word_t if_id_pc,
	output rv_pkg::word_t if_id_inst
);
	import rv_pkg::*;

	localparam int imem_aw = $clog2(imem_depth);

	word_t imem [imem_depth];
	word_t pc;
	logic  advance;

	// ******************************
	// program load
	// byte address, word aligned
	always_ff @(posedge clk) begin
		if (prog_we && rst) begin
			imem[prog_addr[imem_aw+1:2]] <= prog_data;
		end
	end

	// IF/ID slot empty or being taken
	assign advance = !if_id_valid || if_id_ready;

	// ******************************
	// pc and IF/ID register
	always_ff @(posedge clk) begin
		if (rst) begin
			pc          <= '0;
			if_id_valid <= 1'b0;
		end else if (flush) begin
			// wrong-path entry dropped
			pc          <= redirect_pc;
			if_id_valid <= 1'b0;
		end else if (advance) begin
			pc          <= pc + 32'd4;
			if_id_valid <= 1'b1;
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (!flush && advance) begin
			if_id_pc   <= pc;
			if_id_inst <= imem[pc[imem_aw+1:2]];
		end
	end

	// program port only while core is held
	a_prog_in_reset: assert property (@(posedge clk) prog_we |-> rst);

endmodule

//--- hdl/decode_unit.sv
// instruction decode stage
`timescale 1ns/1ps

module decode_unit (
	input  logic             clk,
	input  logic             rst,
	input  logic             if_id_valid,
	output logic             if_id_ready,
	input  rv_pkg::word_t    if_id_pc,
	input  rv_pkg::word_t    if_id_inst,
	output rv_pkg::reg_idx_t rs1,
	output rv_pkg::reg_idx_t rs2,
	input  rv_pkg::word_t    rs1_data,
	input  rv_pkg::word_t    rs2_data,
	input  logic [31:0]      busy,
	input  logic             flush,
	output logic             issue_wen,
	output rv_pkg::reg_idx_t issue_rd,
	output logic             id_ex_valid,
	input  logic             id_ex_ready,
	output rv_pkg::word_t    id_ex_pc,
	output rv_pkg::alu_op_e  id_ex_op,
	output rv_pkg::word_t    id_ex_a,
	output rv_pkg::word_t    id_ex_b,
	output rv_pkg::word_t    id_ex_imm,
	output rv_pkg::reg_idx_t id_ex_rd,
	output logic             id_ex_wen,
	output rv_pkg::kind_e    id_ex_kind
);
	import rv_pkg::*;

	// instruction fields
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t   rd;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;

	// decoded controls
	alu_op_e op;
	kind_e   kind;
	word_t   imm;
	logic    wen;
	logic    use_imm;
	logic    use_rs1;
	logic    use_rs2;

	// handshake
	logic stall;
	logic id_ex_free;
	logic fire;

	// ******************************
	// fields and immediates
	assign opcode = if_id_inst[6:0];
	assign rd     = if_id_inst[11:7];
	assign funct3 = if_id_inst[14:12];
	assign rs1    = if_id_inst[19:15];
	assign rs2    = if_id_inst[24:20];
	assign funct7 = if_id_inst[31:25];

	assign imm_i = {{20{if_id_inst[31]}}, if_id_inst[31:20]};
	assign imm_s = {{20{if_id_inst[31]}}, if_id_inst[31:25], if_id_inst[11:7]};
	assign imm_b = {{19{if_id_inst[31]}}, if_id_inst[31], if_id_inst[7],
		if_id_inst[30:25], if_id_inst[11:8], 1'b0};
	assign imm_u = {if_id_inst[31:12], 12'b0};
	assign imm_j = {{11{if_id_inst[31]}}, if_id_inst[31], if_id_inst[19:12],
		if_id_inst[20], if_id_inst[30:21], 1'b0};

	// ******************************
	// control decode
	// defaults form a no-op that still retires
	always_comb begin
		op      = alu_add;
		kind    = kind_alu;
		imm     = '0;
		wen     = 1'b0;
		use_imm = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode)
			op_lui: begin
				op      = alu_pass_b;
				imm     = imm_u;
				use_imm = 1'b1;
				wen     = 1'b1;
			end
			op_opimm: begin
				imm     = imm_i;
				use_imm = 1'b1;
				use_rs1 = 1'b1;
				wen     = 1'b1;
				case (funct3)
					3'b000: op = alu_add;
					3'b010: op = alu_slt;
					3'b100: op = alu_xor;
					3'b110: op = alu_or;
					3'b111: op = alu_and;
					// sltiu and shift immediates unsupported
					default: wen = 1'b0;
				endcase
			end
			op_op: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				wen     = 1'b1;
				case (funct3)
					3'b000: op = funct7[5] ? alu_sub : alu_add;
					3'b001: op = alu_sll;
					3'b010: op = alu_slt;
					3'b100: op = alu_xor;
					3'b101: begin
						op  = alu_srl;
						// sra unsupported
						wen = !funct7[5];
					end
					3'b110: op = alu_or;
					3'b111: op = alu_and;
					default: wen = 1'b0;
				endcase
			end
			op_load: begin
				// word loads only
				if (funct3 == 3'b010) begin
					kind    = kind_load;
					imm     = imm_i;
					use_rs1 = 1'b1;
					wen     = 1'b1;
				end
			end
			op_store: begin
				if (funct3 == 3'b010) begin
					kind    = kind_store;
					imm     = imm_s;
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
				end
			end
			op_branch: begin
				// sub marks beq, xor marks bne
				if (funct3 == 3'b000 || funct3 == 3'b001) begin
					kind    = kind_branch;
					op      = funct3[0] ? alu_xor : alu_sub;
					imm     = imm_b;
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
				end
			end
			op_jal: begin
				kind = kind_jal;
				imm  = imm_j;
				wen  = 1'b1;
			end
			default: ;
		endcase
	end

	// ******************************
	// hazard and handshake
	// also hold on a busy destination, keeps write order
	assign stall = (use_rs1 && busy[rs1]) || (use_rs2 && busy[rs2]) ||
		(wen && busy[rd]);
	assign id_ex_free  = !id_ex_valid || id_ex_ready;
	assign if_id_ready = id_ex_free && !stall;
	assign fire        = if_id_valid && if_id_ready && !flush;

	// mark destination pending as it leaves
	assign issue_wen = fire && wen && (rd != '0);
	assign issue_rd  = rd;

	// ID/EX register
	always_ff @(posedge clk) begin
		if (rst) begin
			id_ex_valid <= 1'b0;
		end else if (id_ex_free) begin
			id_ex_valid <= fire;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			id_ex_pc   <= if_id_pc;
			id_ex_op   <= op;
			id_ex_a    <= rs1_data;
			id_ex_b    <= use_imm ? imm : rs2_data;
			id_ex_imm  <= imm;
			id_ex_rd   <= rd;
			id_ex_wen  <= wen;
			id_ex_kind <= kind;
		end
	end

endmodule

//--- hdl/execute_unit.sv
// execute stage
`timescale 1ns/1ps

module execute_unit (
	input  logic             clk,
	input  logic             rst,
	input  logic             id_ex_valid,
	output logic             id_ex_ready,
	input  rv_pkg::word_t    id_ex_pc,
	input  rv_pkg::alu_op_e  id_ex_op,
	input  rv_pkg::word_t    id_ex_a,
	input  rv_pkg::word_t    id_ex_b,
	input  rv_pkg::word_t    id_ex_imm,
	input  rv_pkg::reg_idx_t id_ex_rd,
	input  logic             id_ex_wen,
	input  rv_pkg::kind_e    id_ex_kind,
	output logic             flush,
	output rv_pkg::word_t    redirect_pc,
	output logic             ex_mem_valid,
	input  logic             ex_mem_ready,
	output rv_pkg::word_t    ex_mem_result,
	output rv_pkg::word_t    ex_mem_store_data,
	output rv_pkg::reg_idx_t ex_mem_rd,
	output logic             ex_mem_wen,
	output rv_pkg::kind_e    ex_mem_kind,
	output rv_pkg::word_t    ex_mem_pc
);
	import rv_pkg::*;

	word_t alu_out;
	word_t result;
	logic  operands_eq;
	logic  taken;
	logic  fire;

	// ******************************
	// alu
	always_comb begin
		case (id_ex_op)
			alu_add:    alu_out = id_ex_a + id_ex_b;
			alu_sub:    alu_out = id_ex_a - id_ex_b;
			alu_and:    alu_out = id_ex_a & id_ex_b;
			alu_or:     alu_out = id_ex_a | id_ex_b;
			alu_xor:    alu_out = id_ex_a ^ id_ex_b;
			alu_slt:    alu_out = {31'b0, $signed(id_ex_a) < $signed(id_ex_b)};
			alu_sll:    alu_out = id_ex_a << id_ex_b[4:0];
			alu_srl:    alu_out = id_ex_a >> id_ex_b[4:0];
			alu_pass_b: alu_out = id_ex_b;
			default:    alu_out = '0;
		endcase
	end

	// result by kind
	always_comb begin
		case (id_ex_kind)
			kind_load,
			kind_store: result = id_ex_a + id_ex_imm;
			kind_jal:   result = id_ex_pc + 32'd4;
			default:    result = alu_out;
		endcase
	end

	// ******************************
	// branch resolve
	// op sub means beq, xor means bne
	assign operands_eq = (id_ex_a == id_ex_b);
	assign taken = (id_ex_kind == kind_jal) ||
		((id_ex_kind == kind_branch) &&
		((id_ex_op == alu_sub) ? operands_eq : !operands_eq));

	assign id_ex_ready = !ex_mem_valid || ex_mem_ready;
	assign fire        = id_ex_valid && id_ex_ready;

	// one cycle, the branch leaves ID/EX on this edge
	assign flush       = fire && taken;
	assign redirect_pc = id_ex_pc + id_ex_imm;

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem_valid <= 1'b0;
		end else if (id_ex_ready) begin
			ex_mem_valid <= id_ex_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			ex_mem_result     <= result;
			ex_mem_store_data <= id_ex_b;
			ex_mem_rd         <= id_ex_rd;
			ex_mem_wen        <= id_ex_wen;
			ex_mem_kind       <= id_ex_kind;
			ex_mem_pc         <= id_ex_pc;
		end
	end

	// ******************************
	// checks
	// decode drops its entry, so no second flush follows
	a_flush_pulse: assert property (@(posedge clk) disable iff (rst)
		flush |=> !flush);

endmodule

//--- hdl/mem_unit.sv
// memory and writeback stage
`timescale 1ns/1ps

module mem_unit #(
	parameter int dmem_depth = 256
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             ex_mem_valid,
	output logic             ex_mem_ready,
	input  rv_pkg::word_t    ex_mem_result,
	input  rv_pkg::word_t    ex_mem_store_data,
	input  rv_pkg::reg_idx_t ex_mem_rd,
	input  logic             ex_mem_wen,
	input  rv_pkg::kind_e    ex_mem_kind,
	input  rv_pkg::word_t    ex_mem_pc,
	output logic             wb_wen,
	output rv_pkg::reg_idx_t wb_rd,
	output rv_pkg::word_t    wb_data,
	output logic             retire_valid,
	output rv_pkg::word_t    retire_pc,
	output logic             retire_wen,
	output rv_pkg::reg_idx_t retire_rd,
	output rv_pkg::word_t    retire_data
);
	import rv_pkg::*;

	localparam int dmem_aw = $clog2(dmem_depth);

	word_t                dmem [dmem_depth];
	logic [dmem_aw-1:0]   dmem_idx;
	logic                 is_load;
	logic                 is_store;

	// MEM/WB register
	logic     mw_valid;
	logic     mw_wen;
	logic     mw_load;
	reg_idx_t mw_rd;
	word_t    mw_result;
	word_t    mw_pc;
	word_t    mw_load_data;

	// word address, byte offset dropped
	assign dmem_idx = ex_mem_result[dmem_aw+1:2];
	assign is_load  = ex_mem_valid && (ex_mem_kind == kind_load);
	assign is_store = ex_mem_valid && (ex_mem_kind == kind_store);

	// never stalls
	assign ex_mem_ready = 1'b1;

	// ******************************
	// data memory, synchronous
	always_ff @(posedge clk) begin
		if (is_store) begin
			dmem[dmem_idx] <= ex_mem_store_data;
		end
		if (is_load) begin
			mw_load_data <= dmem[dmem_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mw_valid <= 1'b0;
		end else begin
			mw_valid <= ex_mem_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_mem_valid) begin
			mw_wen    <= ex_mem_wen;
			mw_load   <= (ex_mem_kind == kind_load);
			mw_rd     <= ex_mem_rd;
			mw_result <= ex_mem_result;
			mw_pc     <= ex_mem_pc;
		end
	end

	// ******************************
	// writeback and retire
	assign wb_data = mw_load ? mw_load_data : mw_result;
	assign wb_wen  = mw_valid && mw_wen;
	assign wb_rd   = mw_rd;

	assign retire_valid = mw_valid;
	assign retire_pc    = mw_pc;
	assign retire_wen   = mw_wen;
	assign retire_rd    = mw_rd;
	assign retire_data  = wb_data;

endmodule

//--- hdl/core_top.sv
// rv32i pipeline top level
`timescale 1ns/1ps

module core_top #(
	parameter int imem_depth = 256,
	parameter int dmem_depth = 256
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             prog_we,
	input  rv_pkg::word_t    prog_addr,
	input  rv_pkg::word_t    prog_data,
	output logic             retire_valid,
	output rv_pkg::word_t    retire_pc,
	output logic             retire_wen,
	output rv_pkg::reg_idx_t retire_rd,
	output rv_pkg::word_t    retire_data
);
	import rv_pkg::*;

	// ******************************
	// stage links
	logic     if_id_valid;
	logic     if_id_ready;
	word_t    if_id_pc;
	word_t    if_id_inst;

	logic     id_ex_valid;
	logic     id_ex_ready;
	word_t    id_ex_pc;
	alu_op_e  id_ex_op;
	word_t    id_ex_a;
	word_t    id_ex_b;
	word_t    id_ex_imm;
	reg_idx_t id_ex_rd;
	logic     id_ex_wen;
	kind_e    id_ex_kind;

	logic     ex_mem_valid;
	logic     ex_mem_ready;
	word_t    ex_mem_result;
	word_t    ex_mem_store_data;
	reg_idx_t ex_mem_rd;
	logic     ex_mem_wen;
	kind_e    ex_mem_kind;
	word_t    ex_mem_pc;

	// redirect, register file and scoreboard
	logic        flush;
	word_t       redirect_pc;
	reg_idx_t    rs1;
	reg_idx_t    rs2;
	word_t       rs1_data;
	word_t       rs2_data;
	logic        wb_wen;
	reg_idx_t    wb_rd;
	word_t       wb_data;
	logic        issue_wen;
	reg_idx_t    issue_rd;
	logic [31:0] busy;

	fetch_unit #(.imem_depth(imem_depth)) u_fetch (
		.clk, .rst, .prog_we, .prog_addr, .prog_data, .flush, .redirect_pc,
		.if_id_valid, .if_id_ready, .if_id_pc, .if_id_inst
	);

	decode_unit u_decode (
		.clk, .rst, .if_id_valid, .if_id_ready, .if_id_pc, .if_id_inst,
		.rs1, .rs2, .rs1_data, .rs2_data, .busy, .flush, .issue_wen, .issue_rd,
		.id_ex_valid, .id_ex_ready, .id_ex_pc, .id_ex_op, .id_ex_a, .id_ex_b,
		.id_ex_imm, .id_ex_rd, .id_ex_wen, .id_ex_kind
	);

	execute_unit u_execute (
		.clk, .rst, .id_ex_valid, .id_ex_ready, .id_ex_pc, .id_ex_op, .id_ex_a,
		.id_ex_b, .id_ex_imm, .id_ex_rd, .id_ex_wen, .id_ex_kind, .flush,
		.redirect_pc, .ex_mem_valid, .ex_mem_ready, .ex_mem_result,
		.ex_mem_store_data, .ex_mem_rd, .ex_mem_wen, .ex_mem_kind, .ex_mem_pc
	);

	mem_unit #(.dmem_depth(dmem_depth)) u_mem (
		.clk, .rst, .ex_mem_valid, .ex_mem_ready, .ex_mem_result,
		.ex_mem_store_data, .ex_mem_rd, .ex_mem_wen, .ex_mem_kind, .ex_mem_pc,
		.wb_wen, .wb_rd, .wb_data, .retire_valid, .retire_pc, .retire_wen,
		.retire_rd, .retire_data
	);

	reg_file u_regs (
		.clk, .rs1, .rs2, .rs1_data, .rs2_data,
		.wen(wb_wen), .rd(wb_rd), .wdata(wb_data)
	);

	scoreboard u_sb (
		.clk, .rst, .issue_wen, .issue_rd, .wb_wen, .wb_rd, .busy
	);

endmodule

//--- dv/core_tb.sv
// rv32i core testbench
`timescale 1ns/1ps

module core_tb;

	// golden image layout
	// word 0 program length, word 1 trace length
	localparam int golden_words = 256;
	localparam int hdr_words    = 2;
	localparam int drain_cycles = 20;

	logic        clk;
	logic        rst;
	logic        prog_we;
	logic [31:0] prog_addr;
	logic [31:0] prog_data;
	logic        retire_valid;
	logic [31:0] retire_pc;
	logic        retire_wen;
	logic [4:0]  retire_rd;
	logic [31:0] retire_data;

	logic [31:0] golden [golden_words];

	int          prog_len;
	int          trace_len;
	int          timeout_limit;
	int          cycle_count;
	int          retired;
	int          after_reset;
	int          value_errors;
	int          other_errors;
	int          rand_init;
	logic [31:0] last_pc;

	core_top #(
		.imem_depth(256),
		.dmem_depth(256)
	) uut (
		.clk          (clk),
		.rst          (rst),
		.prog_we      (prog_we),
		.prog_addr    (prog_addr),
		.prog_data    (prog_data),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_wen   (retire_wen),
		.retire_rd    (retire_rd),
		.retire_data  (retire_data)
	);

	// 4 ns period
	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ******************************
	// helpers
	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		value_errors++;
		$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
	endtask

	task automatic print_error_counts();
		$display("errors: %0d value mismatches, %0d other failures, %0d of %0d entries retired",
			value_errors, other_errors, retired, trace_len);
	endtask

	// next golden line against the retire port
	task automatic check_retire();
		int          base;
		logic [31:0] exp_pc;
		logic        exp_wen;
		logic [4:0]  exp_rd;
		logic [31:0] exp_data;
		base     = hdr_words + prog_len + 4 * retired;
		exp_pc   = golden[base];
		exp_wen  = golden[base + 1][0];
		exp_rd   = golden[base + 2][4:0];
		exp_data = golden[base + 3];
		if (retire_pc !== exp_pc) begin
			report_value("retire_pc", retire_pc, exp_pc);
		end
		if (retire_wen !== exp_wen) begin
			report_value("retire_wen", {31'b0, retire_wen}, {31'b0, exp_wen});
		end
		// rd and data only defined on a register write
		if (exp_wen) begin
			if (retire_rd !== exp_rd) begin
				report_value("retire_rd", {27'b0, retire_rd}, {27'b0, exp_rd});
			end
			if (retire_data !== exp_data) begin
				report_value("retire_data", retire_data, exp_data);
			end
		end
	endtask

	// ******************************
	// retire monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (rst) begin
			if (retire_valid !== 1'b0) begin
				other_errors++;
				$display("retire_valid is high while reset is held, at %0t ns", $time);
			end
		end else begin
			after_reset++;
			// pipeline still filling
			if (after_reset <= 4 && retire_valid !== 1'b0) begin
				other_errors++;
				$display("retire_valid is high %0d cycles after reset, at %0t ns",
					after_reset, $time);
			end else if (retire_valid === 1'b1) begin
				if (retired < trace_len) begin
					check_retire();
					retired++;
				end else if (retire_pc !== last_pc) begin
					// only the closing self-loop may keep retiring
					other_errors++;
					$display("extra retire at pc %h after the trace ended, at %0t ns",
						retire_pc, $time);
				end
			end
		end
	end

	// ******************************
	// watchdog
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_limit) begin
			other_errors++;
			$display("timeout after %0d cycles, retire entries are missing", cycle_count);
			print_error_counts();
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ******************************
	// stimulus
	initial begin
		int gap;
		int i;
		rand_init     = $urandom(43607);
		rst           = 1'b1;
		prog_we       = 1'b0;
		prog_addr     = '0;
		prog_data     = '0;
		cycle_count   = 0;
		retired       = 0;
		after_reset   = 0;
		value_errors  = 0;
		other_errors  = 0;
		timeout_limit = 100;

		$readmemh("dv/core_golden.txt", golden);
		prog_len  = golden[0];
		trace_len = golden[1];
		if (prog_len == 0 || trace_len == 0 || prog_len > 256 ||
			hdr_words + prog_len + 4 * trace_len > golden_words) begin
			other_errors++;
			$display("golden file is missing or its counts do not fit the image");
			prog_len  = 0;
			trace_len = 0;
		end
		last_pc = '0;
		if (trace_len > 0) begin
			last_pc = golden[hdr_words + prog_len + 4 * (trace_len - 1)];
		end
		// 40 cycles per golden line plus 100
		timeout_limit = 40 * (prog_len + trace_len) + 100;

		// program load with random idle gaps
		for (i = 0; i < prog_len; i++) begin
			gap = $urandom % 3;
			repeat (gap) @(posedge clk) prog_we <= 1'b0;
			@(posedge clk);
			prog_we   <= 1'b1;
			prog_addr <= i * 4;
			prog_data <= golden[hdr_words + i];
		end
		@(posedge clk);
		prog_we <= 1'b0;

		// load port idle for the last reset cycles
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		wait (retired >= trace_len);
		repeat (drain_cycles) @(negedge clk);
		print_error_counts();
		if (value_errors + other_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- dv/core_golden.txt
// counts: program word count, retire trace entry count
// then one program word per line, then the retire trace: pc wen rd data
// rd and data are compared only where wen is 1
0000001F
00000019
123450B7 // 00 lui  x1, 0x12345
00500113 // 04 addi x2, x0, 5
FFD10193 // 08 addi x3, x2, -3
00310233 // 0c add  x4, x2, x3
402182B3 // 10 sub  x5, x3, x2
00527333 // 14 and  x6, x4, x5
0020E3B3 // 18 or   x7, x1, x2
0043C433 // 1c xor  x8, x7, x4
0022A4B3 // 20 slt  x9, x5, x2
00311533 // 24 sll  x10, x2, x3
0030D5B3 // 28 srl  x11, x1, x3
0F016613 // 2c ori  x12, x2, 0xf0
FFF64693 // 30 xori x13, x12, -1
0FF6F713 // 34 andi x14, x13, 0xff
00B72793 // 38 slti x15, x14, 11
00402823 // 3c sw   x4, 16(x0)
01002803 // 40 lw   x16, 16(x0)
00980013 // 44 addi x0, x16, 9
010008B3 // 48 add  x17, x0, x16
00310463 // 4c beq  x2, x3, +8, not taken
00480663 // 50 beq  x16, x4, +12, taken
00100913 // 54 addi x18, x0, 1, wrong path
00200913 // 58 addi x18, x0, 2, wrong path
00311663 // 5c bne  x2, x3, +12, taken
00300993 // 60 addi x19, x0, 3, wrong path
00400993 // 64 addi x19, x0, 4, wrong path
00C00A6F // 68 jal  x20, +12
00500A93 // 6c addi x21, x0, 5, wrong path
00600A93 // 70 addi x21, x0, 6, wrong path
001A0B13 // 74 addi x22, x20, 1
0000006F // 78 jal  x0, 0, closing loop
// retire trace
00000000 1 01 12345000
00000004 1 02 00000005
00000008 1 03 00000002
0000000C 1 04 00000007
00000010 1 05 FFFFFFFD
00000014 1 06 00000005
00000018 1 07 12345005
0000001C 1 08 12345002
00000020 1 09 00000001
00000024 1 0A 00000014
00000028 1 0B 048D1400
0000002C 1 0C 000000F5
00000030 1 0D FFFFFF0A
00000034 1 0E 0000000A
00000038 1 0F 00000001
0000003C 0 00 00000000
00000040 1 10 00000007
00000044 1 00 00000010
00000048 1 11 00000007
0000004C 0 00 00000000
00000050 0 00 00000000
0000005C 0 00 00000000
00000068 1 14 0000006C
00000074 1 16 0000006D
00000078 1 00 0000007C

//--- tb.f
hdl/rv_pkg.sv
hdl/reg_file.sv
hdl/scoreboard.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/mem_unit.sv
hdl/core_top.sv
dv/core_tb.sv
